// File: zports_config.svh
`ifndef ZPORTS_CONFIG_SVH
`define ZPORTS_CONFIG_SVH

////////////////////////////////////////
// port low-byte addresses
////////////////////////////////////////
`define ZP_PORT_FE   8'hFE    // border, beeper, keyboard
`define ZP_PORT_FD   8'hFD    // #7FFD when a15 low
`define ZP_PORT_F7   8'hF7    // #EFF7 when a12 low
`define ZP_KJOY      8'h1F    // kempston joystick, read side
`define ZP_KMOUSE    8'hDF    // kempston mouse
`define ZP_CVX1      8'hFB    // covox
`define ZP_CVX2      8'hDD    // covox, second address
`define ZP_SD0       8'h0F    // soundrive channels
`define ZP_SD1       8'h1F    // write side of #1F
`define ZP_SD2       8'h4F
`define ZP_SD3       8'h5F
`define ZP_XTRD      8'hEF    // extension readback

////////////////////////////////////////
// extension port
////////////////////////////////////////
`define ZP_XT_PORT   16'h55FF
`define ZP_XT_KEY    8'hAA    // unlock byte
`define ZP_XT_BORDER 8'h00    // register numbers
`define ZP_XT_VCFG   8'h08

`endif

// File: zports_pkg.sv
`default_nettype none

package zports_pkg;

	// raw z80 bus as seen by the port block
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  din;
		logic        iorq_n;
		logic        rd_n;
		logic        wr_n;
	} z80_bus_t;

	// decoded port, shadow gating already applied
	typedef enum logic [3:0] {
		SEL_NONE, SEL_FE, SEL_7FFD, SEL_EFF7,
		SEL_CVX, SEL_SD0, SEL_SD1, SEL_SD2, SEL_SD3,
		SEL_KJOY, SEL_MOUSE, SEL_XT, SEL_XTRD
	} port_sel_e;

	// one decoded access, wr/rd are single-cycle strobes
	typedef struct packed {
		port_sel_e   sel;
		logic        wr;
		logic        rd;
		logic [15:0] addr;
		logic [7:0]  data;
	} io_access_t;

	typedef enum logic [1:0] {
		XT_IDLE, XT_ADDR, XT_DATA
	} xt_state_e;

	typedef struct packed {
		logic [7:0] p7ffd;
		logic [7:0] peff7;
		logic [5:0] pent1m_page;   // full 1M page number
		logic       pent1m_rom;
		logic       pent1m_1m_on;
		logic       pent1m_ram0_0;
	} paging_t;

	typedef struct packed {
		logic [7:0] psd0;
		logic [7:0] psd1;
		logic [7:0] psd2;
		logic [7:0] psd3;
	} dac_t;

endpackage

`default_nettype wire

// File: z80_io_strobe.sv
`timescale 1ns/1ns
`default_nettype none

module z80_io_strobe (
	input  wire                  zclk,
	input  wire                  rst_n,
	input  wire zports_pkg::z80_bus_t bus,
	output logic                 wr_stb,
	output logic                 rd_stb
);

	logic io_wr;   // i/o write cycle in progress
	logic io_rd;
	logic io_wr_q;
	logic io_rd_q;

	assign io_wr = ~(bus.iorq_n | bus.wr_n);
	assign io_rd = ~(bus.iorq_n | bus.rd_n);

	// one pulse per z80 cycle, however many zclk it lasts
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			io_wr_q <= 1'b0;
			io_rd_q <= 1'b0;
			wr_stb  <= 1'b0;
			rd_stb  <= 1'b0;
		end
		else
		begin
			io_wr_q <= io_wr;
			io_rd_q <= io_rd;
			wr_stb  <= io_wr & ~io_wr_q;   // rising edge of the cycle
			rd_stb  <= io_rd & ~io_rd_q;
		end
	end

endmodule

`default_nettype wire

// File: port_decoder.sv
`timescale 1ns/1ns
`default_nettype none
`include "zports_config.svh"

module port_decoder (
	input  wire zports_pkg::z80_bus_t bus,
	input  wire                   dos,
	input  wire                   wr_stb,
	input  wire                   rd_stb,
	input  wire                   tape_read,
	input  wire [4:0]             keys_in,
	input  wire [4:0]             kj_in,
	input  wire [7:0]             mus_in,
	input  wire [7:0]             xt_rdata,
	output zports_pkg::io_access_t acc,
	output logic                  porthit,
	output logic                  dataout,
	output logic [7:0]            dout
);

	import zports_pkg::*;

	logic [7:0] loa;
	logic       shadow;
	port_sel_e  sel;

	assign loa    = bus.addr[7:0];
	assign shadow = dos;

	////////////////////////////////////////
	// address classification
	////////////////////////////////////////
	always_comb
	begin
		sel = SEL_NONE;
		if (bus.addr == `ZP_XT_PORT)
			sel = SEL_XT;   // full 16-bit match first, low byte is FF
		else
		begin
			case (loa)
				`ZP_PORT_FE:
					sel = SEL_FE;
				`ZP_PORT_FD:
					if (!bus.addr[15])
						sel = SEL_7FFD;
				`ZP_PORT_F7:
					if (!shadow && !bus.addr[12])
						sel = SEL_EFF7;
				`ZP_CVX1, `ZP_CVX2:
					sel = SEL_CVX;
				`ZP_SD0:
					if (!shadow)
						sel = SEL_SD0;
				// #1F is soundrive on write, joystick on read
				`ZP_SD1:
					if (!shadow)
						sel = bus.wr_n ? SEL_KJOY : SEL_SD1;
				`ZP_SD2:
					if (!shadow)
						sel = SEL_SD2;
				`ZP_SD3:
					if (!shadow)
						sel = SEL_SD3;
				`ZP_KMOUSE:
					sel = SEL_MOUSE;
				`ZP_XTRD:
					sel = SEL_XTRD;
				default:
					sel = SEL_NONE;
			endcase
		end
	end

	// internal port hit, used by the external bus buffers
	always_comb
	begin
		porthit = (loa == `ZP_PORT_FE) || (loa == `ZP_PORT_FD) ||
			((loa == `ZP_PORT_F7) && !shadow) ||
			(loa == `ZP_CVX1) || (loa == `ZP_CVX2) ||
			(!shadow && ((loa == `ZP_SD0) || (loa == `ZP_SD1) ||
				(loa == `ZP_SD2) || (loa == `ZP_SD3) || (loa == `ZP_KJOY))) ||
			(loa == `ZP_KMOUSE) || (loa == `ZP_XTRD);
	end

	assign dataout = porthit & ~bus.iorq_n & ~bus.rd_n;

	////////////////////////////////////////
	// read data mux
	////////////////////////////////////////
	always_comb
	begin
		case (sel)
			SEL_FE:
				dout = {1'b1, tape_read, 1'b0, keys_in};
			SEL_KJOY:
				dout = {3'b000, kj_in};
			SEL_MOUSE:
				dout = mus_in;
			SEL_XTRD:
				dout = xt_rdata;
			default:
				dout = 8'hFF;   // floating bus
		endcase
	end

	assign acc = '{sel: sel, wr: wr_stb, rd: rd_stb, addr: bus.addr, data: bus.din};

endmodule

`default_nettype wire

// File: mem_paging.sv
`timescale 1ns/1ns
`default_nettype none

module mem_paging (
	input  wire                    zclk,
	input  wire                    rst_n,
	input  wire zports_pkg::io_access_t acc,
	input  wire [1:0]              rstrom,   // bit 1 kept for wider rom sets
	output zports_pkg::paging_t    paging
);

	import zports_pkg::*;

	logic [7:0] p7ffd_q;
	logic [7:0] peff7_q;
	logic       rom_q;      // rom bit of #7FFD, held apart
	logic [1:0] rst_sync;
	logic       block1m;
	logic       block7ffd;
	logic       wr_7ffd;

	assign block1m   = peff7_q[2];
	assign block7ffd = p7ffd_q[5] & block1m;
	assign wr_7ffd   = acc.wr && (acc.sel == SEL_7FFD) && !block7ffd;

	// two edges of rom preload after reset release
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			rst_sync <= 2'b11;
		else
			rst_sync <= {rst_sync[0], 1'b0};
	end

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			p7ffd_q <= 8'h00;
			peff7_q <= 8'h00;
		end
		else
		begin
			if (wr_7ffd)
				p7ffd_q <= acc.data;   // 2..0 page, 3 screen, 5 lock 48k
			if (acc.wr && (acc.sel == SEL_EFF7))
				peff7_q <= acc.data;   // 2 block1m, 3 ram0
		end
	end

	always_ff @(posedge zclk)
	begin
		if (rst_sync[1])
			rom_q <= rstrom[0];
		else if (wr_7ffd)
			rom_q <= acc.data[4];
	end

	always_comb
	begin
		paging.p7ffd = {(block1m ? 3'b000 : p7ffd_q[7:5]), rom_q, p7ffd_q[3:0]};
		paging.peff7 = block1m ?
			{peff7_q[7], 1'b0, peff7_q[5:4], 3'b000, peff7_q[0]} : peff7_q;
		paging.pent1m_page   = {p7ffd_q[7:5], p7ffd_q[2:0]};
		paging.pent1m_rom    = p7ffd_q[4];
		paging.pent1m_1m_on  = ~peff7_q[2];
		paging.pent1m_ram0_0 = peff7_q[3];
	end

endmodule

`default_nettype wire

// File: sound_dac.sv
`timescale 1ns/1ns
`default_nettype none

module sound_dac (
	input  wire                    zclk,
	input  wire                    rst_n,
	input  wire zports_pkg::io_access_t acc,
	output zports_pkg::dac_t       dac
);

	import zports_pkg::*;

	dac_t dac_q;
	logic beep;
	logic tape_out;

	assign beep     = acc.data[4];
	assign tape_out = acc.data[3];

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			dac_q <= '0;
		else if (acc.wr)
		begin
			case (acc.sel)
				SEL_FE:
				begin
					dac_q.psd0 <= {8{beep}};
					dac_q.psd1 <= {8{beep}};
					dac_q.psd2 <= {beep, {7{tape_out}}};
					dac_q.psd3 <= {8{tape_out}};
				end
				SEL_CVX:
					dac_q <= {4{acc.data}};   // covox drives all four
				SEL_SD0:
					dac_q.psd0 <= acc.data;
				SEL_SD1:
					dac_q.psd1 <= acc.data;
				SEL_SD2:
					dac_q.psd2 <= acc.data;
				SEL_SD3:
					dac_q.psd3 <= acc.data;
				default:
					dac_q <= dac_q;
			endcase
		end
	end

	assign dac = dac_q;

endmodule

`default_nettype wire

// File: ula_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "zports_config.svh"

module ula_regs (
	input  wire                    zclk,
	input  wire                    rst_n,
	input  wire zports_pkg::io_access_t acc,
	output logic [5:0]             border,
	output logic [7:0]             vcfg,
	output logic [7:0]             xt_rdata
);

	import zports_pkg::*;

	xt_state_e  xt_st;
	logic [7:0] xt_addr;   // latched register number
	logic       xt_wr;

	assign xt_wr = acc.wr && (acc.sel == SEL_XT);

	////////////////////////////////////////
	// #55FF unlock sequence
	////////////////////////////////////////
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			xt_st   <= XT_IDLE;
			xt_addr <= 8'h00;
		end
		else if (acc.wr && !xt_wr)
			xt_st <= XT_IDLE;   // any other port write locks again
		else if (xt_wr)
		begin
			case (xt_st)
				XT_IDLE:
					if (acc.data == `ZP_XT_KEY)
						xt_st <= XT_ADDR;
				XT_ADDR:
				begin
					xt_addr <= acc.data;
					xt_st   <= XT_DATA;
				end
				default:
					xt_st <= XT_IDLE;   // data phase done
			endcase
		end
	end

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border <= 6'd0;
			vcfg   <= 8'h00;
		end
		else if (acc.wr && (acc.sel == SEL_FE))
			border <= {acc.data[1], 1'b0, acc.data[2], 1'b0, acc.data[0], 1'b0};
		else if (xt_wr && (xt_st == XT_DATA))
		begin
			if (xt_addr == `ZP_XT_BORDER)
				border <= acc.data[5:0];
			else if (xt_addr == `ZP_XT_VCFG)
				vcfg <= acc.data;
		end
	end

	// only the border register reads back
	assign xt_rdata = (xt_addr == `ZP_XT_BORDER) ? {2'b00, border} : 8'hFF;

endmodule

`default_nettype wire

// File: zports_top.sv
`timescale 1ns/1ns
`default_nettype none

module zports_top (
	input  wire                   zclk,
	input  wire                   rst_n,
	input  wire zports_pkg::z80_bus_t bus,
	input  wire                   dos,
	input  wire [4:0]             keys_in,
	input  wire                   tape_read,
	input  wire [4:0]             kj_in,
	input  wire [7:0]             mus_in,
	input  wire [1:0]             rstrom,
	output logic [7:0]            dout,
	output logic                  dataout,
	output logic                  porthit,
	output logic [5:0]            border,
	output logic [7:0]            vcfg,
	output zports_pkg::paging_t   paging,
	output zports_pkg::dac_t      dac
);

	import zports_pkg::*;

	logic       wr_stb;
	logic       rd_stb;
	io_access_t acc;
	logic [7:0] xt_rdata;

	z80_io_strobe z80_io_strobe_i (
		.zclk   (zclk),
		.rst_n  (rst_n),
		.bus    (bus),
		.wr_stb (wr_stb),
		.rd_stb (rd_stb)
	);

	port_decoder port_decoder_i (
		.bus       (bus),
		.dos       (dos),
		.wr_stb    (wr_stb),
		.rd_stb    (rd_stb),
		.tape_read (tape_read),
		.keys_in   (keys_in),
		.kj_in     (kj_in),
		.mus_in    (mus_in),
		.xt_rdata  (xt_rdata),
		.acc       (acc),
		.porthit   (porthit),
		.dataout   (dataout),
		.dout      (dout)
	);

	mem_paging mem_paging_i (
		.zclk   (zclk),
		.rst_n  (rst_n),
		.acc    (acc),
		.rstrom (rstrom),
		.paging (paging)
	);

	sound_dac sound_dac_i (
		.zclk  (zclk),
		.rst_n (rst_n),
		.acc   (acc),
		.dac   (dac)
	);

	ula_regs ula_regs_i (
		.zclk     (zclk),
		.rst_n    (rst_n),
		.acc      (acc),
		.border   (border),
		.vcfg     (vcfg),
		.xt_rdata (xt_rdata)
	);

endmodule

`default_nettype wire

// File: tb_zports.sv
`timescale 1ns/1ns
`default_nettype none

module tb_zports;

	import zports_pkg::*;

	logic       zclk;
	logic       rst_n;
	z80_bus_t   bus;
	logic       dos;
	logic [4:0] keys_in;
	logic       tape_read;
	logic [4:0] kj_in;
	logic [7:0] mus_in;
	logic [1:0] rstrom;
	logic [7:0] dout;
	logic       dataout;
	logic       porthit;
	logic [5:0] border;
	logic [7:0] vcfg;
	paging_t    paging;
	dac_t       dac;

	// model of the port registers
	logic [5:0] m_border;
	logic [7:0] m_vcfg;
	dac_t       m_dac;
	logic [7:0] m_7ffd;       // raw #7FFD contents
	logic       m_rom;
	logic [7:0] m_eff7;

	logic [7:0]  smp_dout;     // sampled mid-access
	logic        smp_hit;
	logic        smp_dataout;
	logic [7:0]  d;
	logic [15:0] sd_port [4];
	logic [15:0] odd_port [3];
	integer      seed;
	int          err_count;
	int          timeout_count;
	int          i;
	int          cnt;

	zports_top zports_top_i (
		.zclk      (zclk),
		.rst_n     (rst_n),
		.bus       (bus),
		.dos       (dos),
		.keys_in   (keys_in),
		.tape_read (tape_read),
		.kj_in     (kj_in),
		.mus_in    (mus_in),
		.rstrom    (rstrom),
		.dout      (dout),
		.dataout   (dataout),
		.porthit   (porthit),
		.border    (border),
		.vcfg      (vcfg),
		.paging    (paging),
		.dac       (dac)
	);

	always #10 zclk = ~zclk;

	task check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp)
		else
		begin
			$display("FAIL %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
			err_count++;
		end
	endtask

	////////////////////////////////////////
	// z80 bus cycles
	////////////////////////////////////////
	task run_access(input logic [15:0] addr, input logic [7:0] data, input logic is_wr);
		int   n;
		logic seen;
		@(negedge zclk);
		bus.addr   = addr;
		bus.din    = data;
		bus.iorq_n = 1'b0;
		bus.wr_n   = !is_wr;
		bus.rd_n   = is_wr;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < 4)   // strobe due one cycle after the first edge
		begin
			@(negedge zclk);
			n++;
			seen = is_wr ? zports_top_i.wr_stb : zports_top_i.rd_stb;
		end
		if (!seen)
		begin
			$display("timeout: no access strobe from the DUT for port %h", addr);
			timeout_count++;
		end
		smp_dout    = dout;
		smp_hit     = porthit;
		smp_dataout = dataout;
		while (n < 3)   // three cycles active
		begin
			@(negedge zclk);
			n++;
		end
		bus.iorq_n = 1'b1;
		bus.wr_n   = 1'b1;
		bus.rd_n   = 1'b1;
		n = 0;
		while (n < 2)
		begin
			@(negedge zclk);
			n++;
		end
	endtask

	task io_write(input logic [15:0] addr, input logic [7:0] data);
		run_access(addr, data, 1'b1);
	endtask

	task io_read(input logic [15:0] addr);
		run_access(addr, 8'h00, 1'b0);
	endtask

	////////////////////////////////////////
	// expected values
	////////////////////////////////////////
	function automatic logic [7:0] exp_p7ffd();
		return {(m_eff7[2] ? 3'b000 : m_7ffd[7:5]), m_rom, m_7ffd[3:0]};
	endfunction

	function automatic logic [7:0] exp_peff7();
		if (m_eff7[2])
			return {m_eff7[7], 1'b0, m_eff7[5:4], 3'b000, m_eff7[0]};
		return m_eff7;
	endfunction

	task apply_fe(input logic [7:0] v);
		m_border  = {v[1], 1'b0, v[2], 1'b0, v[0], 1'b0};
		m_dac.psd0 = {8{v[4]}};   // beeper
		m_dac.psd1 = {8{v[4]}};
		m_dac.psd2 = {v[4], {7{v[3]}}};
		m_dac.psd3 = {8{v[3]}};   // tape out
	endtask

	task check_state(input string where);
		check_value(32'(border), 32'(m_border), {where, ": border"});
		check_value(32'(vcfg), 32'(m_vcfg), {where, ": vcfg"});
		check_value(32'(dac.psd0), 32'(m_dac.psd0), {where, ": psd0"});
		check_value(32'(dac.psd1), 32'(m_dac.psd1), {where, ": psd1"});
		check_value(32'(dac.psd2), 32'(m_dac.psd2), {where, ": psd2"});
		check_value(32'(dac.psd3), 32'(m_dac.psd3), {where, ": psd3"});
		check_value(32'(paging.p7ffd), 32'(exp_p7ffd()), {where, ": p7ffd"});
		check_value(32'(paging.peff7), 32'(exp_peff7()), {where, ": peff7"});
		check_value(32'(paging.pent1m_page), 32'({m_7ffd[7:5], m_7ffd[2:0]}),
			{where, ": pent1m_page"});
		check_value(32'(paging.pent1m_rom), 32'(m_7ffd[4]), {where, ": pent1m_rom"});
		check_value(32'(paging.pent1m_1m_on), 32'(!m_eff7[2]), {where, ": pent1m_1m_on"});
		check_value(32'(paging.pent1m_ram0_0), 32'(m_eff7[3]), {where, ": pent1m_ram0_0"});
	endtask

	task write_7ffd(input logic [7:0] v);
		io_write(16'h7FFD, v);
		if (!(m_7ffd[5] && m_eff7[2]))   // locked while 48k lock and block1m
		begin
			m_7ffd = v;
			m_rom  = v[4];
		end
		check_state("7ffd write");
	endtask

	task write_eff7(input logic [7:0] v);
		io_write(16'hEFF7, v);
		if (!dos)
			m_eff7 = v;
		check_state("eff7 write");
	endtask

	task check_read(input logic [7:0] exp, input logic hit, input string what);
		check_value(32'(smp_dout), 32'(exp), {what, ": dout"});
		check_value(32'(smp_hit), 32'(hit), {what, ": porthit"});
		check_value(32'(smp_dataout), 32'(hit), {what, ": dataout"});
	endtask

	initial
	begin
		zclk          = 1'b0;
		rst_n         = 1'b0;
		bus           = '{addr: 16'h0000, din: 8'h00, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1};
		dos           = 1'b0;
		keys_in       = 5'h1F;
		tape_read     = 1'b0;
		kj_in         = 5'h00;
		mus_in        = 8'hFF;
		rstrom        = 2'b01;
		seed          = 48;
		err_count     = 0;
		timeout_count = 0;
		m_border      = 6'd0;
		m_vcfg        = 8'h00;
		m_dac         = '0;
		m_7ffd        = 8'h00;
		m_rom         = 1'b1;   // rstrom[0]
		m_eff7        = 8'h00;
		sd_port       = '{16'h000F, 16'h001F, 16'h004F, 16'h005F};
		odd_port      = '{16'h003B, 16'h1280, 16'hA5A5};

		for (cnt = 0; cnt < 8; cnt++)
			@(negedge zclk);
		rst_n = 1'b1;
		for (cnt = 0; cnt < 3; cnt++)   // let the rom preload finish
			@(negedge zclk);

		////////////////////////////////////////
		// reset state, locked extension port
		check_state("after reset");
		io_write(16'h55FF, 8'h33);
		io_write(16'h55FF, 8'h00);
		io_write(16'h55FF, 8'h15);
		check_state("55ff without key");

		// port FE
		for (i = 0; i < 4; i++)
		begin
			d = 8'($random(seed));
			io_write(16'h7EFE, d);
			apply_fe(d);
			check_state("fe write");
			keys_in   = 5'($random(seed));
			tape_read = 1'($random(seed));
			io_read(16'hFEFE);
			check_read({1'b1, tape_read, 1'b0, keys_in}, 1'b1, "fe read");
		end

		////////////////////////////////////////
		// covox and soundrive
		d = 8'($random(seed));
		io_write(16'h00FB, d);
		m_dac = {4{d}};
		check_state("covox fb");
		d = 8'($random(seed));
		io_write(16'h00DD, d);
		m_dac = {4{d}};
		check_state("covox dd");
		for (i = 0; i < 4; i++)
		begin
			d = 8'($random(seed));
			io_write(sd_port[i], d);
			case (i)
				0: m_dac.psd0 = d;
				1: m_dac.psd1 = d;
				2: m_dac.psd2 = d;
				default: m_dac.psd3 = d;
			endcase
			check_state("soundrive");
		end
		dos = 1'b1;   // shadow hides soundrive
		for (i = 0; i < 4; i++)
		begin
			io_write(sd_port[i], 8'($random(seed)));
			check_value(32'(smp_hit), 32'd0, "soundrive porthit in shadow");
			check_state("soundrive in shadow");
		end
		dos = 1'b0;

		////////////////////////////////////////
		// memory paging
		write_7ffd(8'h13);
		write_eff7(8'h08);
		for (i = 0; i < 3; i++)
			write_7ffd(8'($random(seed)) & 8'hDF);
		write_7ffd(8'hB5);
		write_eff7(8'h4E);   // block1m on
		write_7ffd(8'h02);   // locked so no change
		dos = 1'b1;
		write_eff7(8'h00);
		dos = 1'b0;
		write_eff7(8'h00);
		write_7ffd(8'h07);

		// extension port
		d = 8'($random(seed));
		io_write(16'h55FF, 8'hAA);
		io_write(16'h55FF, 8'h00);
		io_write(16'h55FF, d);
		m_border = d[5:0];
		check_state("xt border");
		io_read(16'h00EF);
		check_read({2'b00, m_border}, 1'b1, "xt border readback");
		d = 8'($random(seed));
		io_write(16'h55FF, 8'hAA);
		io_write(16'h55FF, 8'h08);
		io_write(16'h55FF, d);
		m_vcfg = d;
		check_state("xt vcfg");
		io_read(16'h12EF);
		check_read(8'hFF, 1'b1, "xt vcfg readback");
		d = 8'($random(seed));
		io_write(16'h55FF, 8'hAA);
		io_write(16'h00FE, d);   // breaks the sequence
		apply_fe(d);
		io_write(16'h55FF, 8'h08);
		io_write(16'h55FF, ~m_vcfg);
		check_state("xt broken sequence");

		////////////////////////////////////////
		// joystick, mouse, unlisted ports
		kj_in = 5'($random(seed));
		io_read(16'h001F);
		check_read({3'b000, kj_in}, 1'b1, "kempston joystick");
		mus_in = 8'($random(seed));
		io_read(16'hFADF);
		check_read(mus_in, 1'b1, "kempston mouse");
		for (i = 0; i < 3; i++)
		begin
			io_read(odd_port[i]);
			check_read(8'hFF, 1'b0, "unlisted port");
		end

		$display("summary: %0d check errors, %0d timeouts", err_count, timeout_count);
		if (err_count == 0 && timeout_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
zports_pkg.sv
z80_io_strobe.sv
port_decoder.sv
mem_paging.sv
sound_dac.sv
ula_regs.sv
zports_top.sv
tb_zports.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns -f src.f --top-module tb_zports \
	-o tb_zports > build.log 2>&1 &&
./obj_dir/tb_zports > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "SIMULATION FAILED" sim.log && { echo "test failed"; exit 1; }
echo "test passed"
exit 0
